// ==== ialu.f ====
+incdir+include
src/ialu_op_pkg.sv
src/ialu_ctrl_pkg.sv
src/ialu_basic_unit.sv
src/ialu_seq_mul.sv
src/ialu_ctrl.sv
src/ialu_top.sv
sim/ialu_asserts.sv
sim/ialu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ialu testbench with Verilator, run it and search the log for the pass message
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ialu_tb \
    -f ialu.f -o ialu_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/ialu_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "^Simulation completed successfully$" sim.log && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== sim/ialu_tb.sv ====
// ialu testbench
// Table of directed operations and random multiplies over the req/ack handshake

`timescale 1ns/1ps
`include "ialu_defs.svh"

module ialu_tb;

    import ialu_op_pkg::*;
    import ialu_ctrl_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;    // Inputs change after the rising edge
    localparam int NUM_TABLE   = 24;
    localparam int NUM_RAND    = 16;
    localparam int NUM_TESTS   = NUM_TABLE + NUM_RAND;
    localparam int PHASE_LIMIT = 40;   // Cycles allowed per handshake phase
    localparam int WATCHDOG    = NUM_TESTS * 40 + 100;

    typedef struct packed {
        ialu_cmd_e              cmd;
        logic [`IALU_XLEN-1:0]  op1;
        logic [`IALU_XLEN-1:0]  op2;
        logic [`IALU_XLEN-1:0]  res;    // Expected result
        logic                   cmp;    // Expected compare flag
    } vec_s;

    logic       clk;
    logic       rst_n;
    logic       req;
    ialu_req_s  req_data;
    logic       ack;
    ialu_rsp_s  rsp;

    vec_s        vectors [NUM_TABLE];
    ialu_cmd_e   mul_cmds [4] = '{CMD_MUL, CMD_MULH, CMD_MULHSU, CMD_MULHU};
    logic [31:0] lfsr = 32'd27572;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    ialu_top ialu_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //--------------------------------------------------
    // Stimulus helpers
    //--------------------------------------------------
    function automatic vec_s make_vec(input ialu_cmd_e cmd, input logic [31:0] a,
                                      input logic [31:0] b, input logic [31:0] r,
                                      input logic c);
        vec_s v;
        v.cmd = cmd;
        v.op1 = a;
        v.op2 = b;
        v.res = r;
        v.cmp = c;
        return v;
    endfunction

    function automatic void load_table();
        vectors[ 0] = make_vec(CMD_AND,    32'hF0F0_1234, 32'h0FF0_FF00, 32'h00F0_1200, 1'b0);
        vectors[ 1] = make_vec(CMD_OR,     32'hF000_0001, 32'h0000_1230, 32'hF000_1231, 1'b0);
        vectors[ 2] = make_vec(CMD_XOR,    32'hFFFF_0000, 32'h0F0F_0F0F, 32'hF0F0_0F0F, 1'b0);
        vectors[ 3] = make_vec(CMD_ADD,    32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 1'b0);
        vectors[ 4] = make_vec(CMD_ADD,    32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000, 1'b0);
        vectors[ 5] = make_vec(CMD_SUB,    32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 1'b0);
        vectors[ 6] = make_vec(CMD_SLT,    32'h8000_0000, 32'h0000_0001, 32'h0000_0001, 1'b1);
        vectors[ 7] = make_vec(CMD_SLTU,   32'h8000_0000, 32'h0000_0001, 32'h0000_0000, 1'b0);
        vectors[ 8] = make_vec(CMD_SLTU,   32'h0000_0005, 32'hFFFF_FFFF, 32'h0000_0001, 1'b1);
        vectors[ 9] = make_vec(CMD_SEQ,    32'hDEAD_BEEF, 32'hDEAD_BEEF, 32'h0000_0001, 1'b1);
        vectors[10] = make_vec(CMD_SNE,    32'hDEAD_BEEF, 32'hDEAD_BEEF, 32'h0000_0000, 1'b0);
        vectors[11] = make_vec(CMD_SGE,    32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000, 1'b0);
        vectors[12] = make_vec(CMD_SGEU,   32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0001, 1'b1);
        vectors[13] = make_vec(CMD_SLL,    32'h0000_0001, 32'h0000_0024, 32'h0000_0010, 1'b0);
        vectors[14] = make_vec(CMD_SRL,    32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0);
        vectors[15] = make_vec(CMD_SRA,    32'h8000_0000, 32'h0000_0004, 32'hF800_0000, 1'b0);
        vectors[16] = make_vec(CMD_SRA,    32'h7000_0000, 32'h0000_0021, 32'h3800_0000, 1'b0);
        vectors[17] = make_vec(CMD_MUL,    32'hFFFF_FFFF, 32'h0000_0003, 32'hFFFF_FFFD, 1'b0);
        vectors[18] = make_vec(CMD_MULH,   32'hFFFF_FFFF, 32'h0000_0003, 32'hFFFF_FFFF, 1'b0);
        vectors[19] = make_vec(CMD_MULHSU, 32'h8000_0000, 32'h8000_0000, 32'hC000_0000, 1'b0);
        vectors[20] = make_vec(CMD_MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 1'b0);
        vectors[21] = make_vec(CMD_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 1'b0);
        vectors[22] = make_vec(CMD_MUL,    32'h1234_5678, 32'h0000_0000, 32'h0000_0000, 1'b0);
        vectors[23] = make_vec(CMD_MULHU,  32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0);
    endfunction

    // 32-bit Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            w    = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] mul_expect(input ialu_cmd_e cmd, input logic [31:0] a,
                                               input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        prod;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'd0, a};
        ub = {32'd0, b};
        case (cmd)
            CMD_MUL,
            CMD_MULH:   prod = sa * sb;
            CMD_MULHSU: prod = sa * $signed(ub);
            default:    prod = ua * ub;
        endcase
        return (cmd == CMD_MUL) ? prod[31:0] : prod[63:32];
    endfunction

    //--------------------------------------------------
    // Handshake and checking
    //--------------------------------------------------
    task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", sig, got, exp);
            error_count++;
        end
    endtask

    // Called 2 ns after a rising edge, returns at the same point of a later cycle
    task automatic exchange(input ialu_req_s rq, output ialu_rsp_s got, output int latency);
        int cycles;
        req_data = rq;
        req      = 1'b1;
        cycles   = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end while (!ack && cycles < PHASE_LIMIT);
        got     = rsp;
        latency = cycles;   // Edges from req to ack
        if (!ack) begin
            $display("ack did not rise within %0d cycles of req", PHASE_LIMIT);
            error_count++;
        end
        req    = 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end while (ack && cycles < PHASE_LIMIT);
        if (ack) begin
            $display("ack stayed high for %0d cycles after req dropped", PHASE_LIMIT);
            error_count++;
        end
    endtask

    task automatic run_test(input int idx, input vec_s v);
        ialu_req_s rq;
        ialu_rsp_s got;
        int        latency;
        logic      single_cycle;
        int        errs_before;
        errs_before = error_count;
        rq.cmd = v.cmd;
        rq.op1 = v.op1;
        rq.op2 = v.op2;
        // Multiplies with a zero operand skip the iterative multiplier
        single_cycle = !(v.cmd inside {CMD_MUL, CMD_MULH, CMD_MULHSU, CMD_MULHU})
                     || (v.op1 == '0) || (v.op2 == '0);
        exchange(rq, got, latency);
        check_value("rsp.res", got.res, v.res);
        check_value("rsp.cmp", {31'd0, got.cmp}, {31'd0, v.cmp});
        if (single_cycle) begin
            check_value("ack_latency", latency, 32'd1);
        end
        if (error_count == errs_before) pass_count++;
        else fail_count++;
        $display("test %2d %-10s op1=0x%08h op2=0x%08h res=0x%08h cmp=%0d %s", idx,
                 v.cmd.name(), v.op1, v.op2, got.res, got.cmp,
                 (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    //--------------------------------------------------
    // Main sequence
    //--------------------------------------------------
    initial begin
        vec_s        v;
        logic [31:0] a;
        logic [31:0] b;
        rst_n    = 1'b0;
        req      = 1'b0;
        req_data = '0;
        load_table();
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        for (int i = 0; i < NUM_TABLE; i++) begin
            run_test(i, vectors[i]);
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            a = next_word();
            b = next_word();
            v = make_vec(mul_cmds[i % 4], a, b, mul_expect(mul_cmds[i % 4], a, b), 1'b0);
            run_test(NUM_TABLE + i, v);
        end
        error_count += ialu_top_inst.ialu_ctrl_inst.ialu_asserts_inst.fail_cnt;
        $display("Tests: %0d run, %0d passed, %0d failed, %0d errors", NUM_TESTS,
                 pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== sim/ialu_asserts.sv ====
// ialu handshake assertions
// Bound to the control block, checks the req/ack protocol and the FSM

`timescale 1ns/1ps

module ialu_asserts (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         req,
    input logic                         ack,
    input logic                         mul_start,
    input logic                         mul_done,
    input ialu_ctrl_pkg::ialu_state_e   state
);

    import ialu_ctrl_pkg::*;

    int unsigned fail_cnt = 0;  // Read by the testbench summary

    //--------------------------------------------------
    // Handshake
    //--------------------------------------------------
    ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
    else begin
        $error("ack rose while req was low");
        fail_cnt = fail_cnt + 1;
    end

    ack_fall_needs_req_low: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
    else begin
        $error("ack fell while req was still high");
        fail_cnt = fail_cnt + 1;
    end

    // Entered with the start pulse, left on the first done
    mul_wait_window: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_MUL_WAIT) |->
            (mul_start || ($past(state == ST_MUL_WAIT) && !$past(mul_done))))
    else begin
        $error("MUL_WAIT held outside the start to done window");
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind ialu_ctrl ialu_asserts ialu_asserts_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .ack        (ack),
    .mul_start  (mul_start),
    .mul_done   (mul_done),
    .state      (state)
);

// ==== src/ialu_top.sv ====
// ialu top level
// Single-cycle unit, sequential multiplier and handshake control

`timescale 1ns/1ps
`include "ialu_defs.svh"

module ialu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,
    input  ialu_op_pkg::ialu_req_s  req_data,
    output logic                    ack,
    output ialu_op_pkg::ialu_rsp_s  rsp
);

    import ialu_op_pkg::*;

    ialu_rsp_s              basic_rsp;
    logic                   zero_op;    // Multiply shortcut
    logic                   mul_start;
    logic                   mul_done;
    logic [`IALU_XLEN-1:0]  mul_res;

    assign zero_op = ~|req_data.op1 | ~|req_data.op2;

    ialu_basic_unit ialu_basic_unit_inst (
        .req  (req_data),
        .rsp  (basic_rsp)
    );

    ialu_seq_mul ialu_seq_mul_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (req_data.cmd),
        .op1      (req_data.op1),
        .op2      (req_data.op2),
        .start    (mul_start),
        .done     (mul_done),
        .mul_res  (mul_res)
    );

    ialu_ctrl ialu_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .cmd        (req_data.cmd),
        .zero_op    (zero_op),
        .basic_rsp  (basic_rsp),
        .mul_res    (mul_res),
        .mul_done   (mul_done),
        .mul_start  (mul_start),
        .ack        (ack),
        .rsp        (rsp)
    );

endmodule

// ==== src/ialu_ctrl.sv ====
// ialu control
// Four-phase req/ack FSM, multiplier launch and the registered response

`timescale 1ns/1ps
`include "ialu_defs.svh"

module ialu_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,
    input  ialu_op_pkg::ialu_cmd_e  cmd,
    input  logic                    zero_op,
    input  ialu_op_pkg::ialu_rsp_s  basic_rsp,
    input  logic [`IALU_XLEN-1:0]   mul_res,
    input  logic                    mul_done,
    output logic                    mul_start,
    output logic                    ack,
    output ialu_op_pkg::ialu_rsp_s  rsp
);

    import ialu_op_pkg::*;
    import ialu_ctrl_pkg::*;

    ialu_state_e state;
    ialu_state_e state_nxt;
    logic        use_mul;   // Operation goes through the multiplier

    // A zero operand takes the single-cycle path, basic_rsp is already 0
    assign use_mul = (cmd inside {CMD_MUL, CMD_MULH, CMD_MULHSU, CMD_MULHU}) && !zero_op;

    //--------------------------------------------------
    // Handshake FSM
    //--------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:     if (req) state_nxt = use_mul ? ST_MUL_WAIT : ST_DONE;
            ST_MUL_WAIT: if (mul_done) state_nxt = ST_DONE;
            ST_DONE:     if (!req) state_nxt = ST_IDLE;
            default:     state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            mul_start <= 1'b0;
        end else begin
            state     <= state_nxt;
            mul_start <= (state == ST_IDLE) && req && use_mul;
        end
    end

    assign ack = (state == ST_DONE);

    //--------------------------------------------------
    // Response register
    //--------------------------------------------------
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && req && !use_mul) begin
            rsp <= basic_rsp;
        end else if ((state == ST_MUL_WAIT) && mul_done) begin
            rsp.res <= mul_res;
            rsp.cmp <= 1'b0;                    // No compare for multiplies
        end
    end

endmodule

// ==== src/ialu_seq_mul.sv ====
// ialu sequential multiplier
// Radix-2 shift-add, one op2 bit per cycle, high or low product word out

`timescale 1ns/1ps
`include "ialu_defs.svh"

module ialu_seq_mul (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ialu_op_pkg::ialu_cmd_e  cmd,
    input  logic [`IALU_XLEN-1:0]   op1,
    input  logic [`IALU_XLEN-1:0]   op2,
    input  logic                    start,
    output logic                    done,
    output logic [`IALU_XLEN-1:0]   mul_res
);

    import ialu_op_pkg::*;
    import ialu_ctrl_pkg::*;

    ialu_mul_state_e            state;
    logic [`IALU_CNT_W-1:0]     cnt;        // Remaining iterations minus one
    logic                       last_iter;
    logic                       op1_sgn;
    logic                       op2_sgn;
    logic                       op2_sgn_q;  // Final step subtracts
    logic                       sel_hi;     // Return the high word
    logic [`IALU_XLEN:0]        mcand;      // op1 extended to 33 bits
    logic [`IALU_XLEN:0]        hi;         // Partial product, high part
    logic [`IALU_XLEN-1:0]      lo;         // op2 bits, then product low part
    logic [`IALU_XLEN+1:0]      addend;
    logic [`IALU_XLEN+1:0]      sum;

    assign op1_sgn   = (cmd == CMD_MUL) || (cmd == CMD_MULH) || (cmd == CMD_MULHSU);
    assign op2_sgn   = (cmd == CMD_MUL) || (cmd == CMD_MULH);
    assign last_iter = (cnt == '0);

    //--------------------------------------------------
    // Iteration step
    //--------------------------------------------------
    always_comb begin
        addend = lo[0] ? {mcand[`IALU_XLEN], mcand} : '0;
        // Top op2 bit weighs -2^31 when op2 is signed
        if (last_iter && op2_sgn_q) begin
            sum = {hi[`IALU_XLEN], hi} - addend;
        end else begin
            sum = {hi[`IALU_XLEN], hi} + addend;
        end
    end

    //--------------------------------------------------
    // Control and counter
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= MUL_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= (state == MUL_ITER) && last_iter;   // One-cycle pulse
            case (state)
                MUL_IDLE: if (start) begin
                    state <= MUL_ITER;
                    cnt   <= `IALU_CNT_W'(`IALU_MUL_ITERS - 1);
                end
                default: begin
                    cnt <= cnt - 1'b1;
                    if (last_iter) state <= MUL_IDLE;
                end
            endcase
        end
    end

    // Product registers
    always_ff @(posedge clk) begin
        if ((state == MUL_IDLE) && start) begin
            mcand     <= {op1_sgn & op1[`IALU_XLEN-1], op1};
            hi        <= '0;
            lo        <= op2;
            op2_sgn_q <= op2_sgn;
            sel_hi    <= (cmd != CMD_MUL);
        end else if (state == MUL_ITER) begin
            hi <= sum[`IALU_XLEN+1:1];                  // Arithmetic shift right
            lo <= {sum[0], lo[`IALU_XLEN-1:1]};
        end
    end

    assign mul_res = sel_hi ? hi[`IALU_XLEN-1:0] : lo;

endmodule

// ==== src/ialu_basic_unit.sv ====
// ialu single-cycle unit
// Logic ops, main adder with flags, compares and shifter

`timescale 1ns/1ps
`include "ialu_defs.svh"

module ialu_basic_unit (
    input  ialu_op_pkg::ialu_req_s  req,
    output ialu_op_pkg::ialu_rsp_s  rsp
);

    import ialu_op_pkg::*;
    import ialu_ctrl_pkg::*;

    logic                       sub;        // Main adder subtracts
    logic [`IALU_XLEN:0]        sum;        // Result with carry out
    ialu_flags_s                flags;
    logic                       lt_s;       // Signed less than
    logic [`IALU_SHAMT_W-1:0]   shamt;
    logic [`IALU_XLEN-1:0]      shft_res;

    //--------------------------------------------------
    // Main adder and flags
    //--------------------------------------------------
    always_comb begin
        sub = (req.cmd != CMD_ADD);
        if (sub) begin
            sum = {1'b0, req.op1} - {1'b0, req.op2};
        end else begin
            sum = {1'b0, req.op1} + {1'b0, req.op2};
        end
        flags.carry = sum[`IALU_XLEN];
        flags.zero  = ~|sum[`IALU_XLEN-1:0];
        flags.sign  = sum[`IALU_XLEN-1];
        // Operands of equal effective sign giving a result of the other sign
        flags.ovf   = (req.op1[`IALU_XLEN-1] == (req.op2[`IALU_XLEN-1] ^ sub))
                    & (sum[`IALU_XLEN-1] != req.op1[`IALU_XLEN-1]);
    end

    assign lt_s = flags.sign ^ flags.ovf;

    //--------------------------------------------------
    // Shifter
    //--------------------------------------------------
    assign shamt = req.op2[`IALU_SHAMT_W-1:0];    // Upper op2 bits ignored

    always_comb begin
        case (req.cmd)
            CMD_SRL: shft_res = req.op1 >> shamt;
            CMD_SRA: shft_res = $signed(req.op1) >>> shamt;  // Sign fill
            default: shft_res = req.op1 << shamt;
        endcase
    end

    //--------------------------------------------------
    // Result forming
    //--------------------------------------------------
    always_comb begin
        rsp.res = '0;
        rsp.cmp = 1'b0;
        case (req.cmd)
            CMD_AND:  rsp.res = req.op1 & req.op2;
            CMD_OR:   rsp.res = req.op1 | req.op2;
            CMD_XOR:  rsp.res = req.op1 ^ req.op2;
            CMD_ADD,
            CMD_SUB:  rsp.res = sum[`IALU_XLEN-1:0];
            CMD_SLT:  rsp.cmp = lt_s;
            CMD_SLTU: rsp.cmp = flags.carry;
            CMD_SEQ:  rsp.cmp = flags.zero;
            CMD_SNE:  rsp.cmp = ~flags.zero;
            CMD_SGE:  rsp.cmp = ~lt_s;
            CMD_SGEU: rsp.cmp = ~flags.carry;
            CMD_SLL,
            CMD_SRL,
            CMD_SRA:  rsp.res = shft_res;
            default: begin
            end                                         // NOP and multiplies give 0
        endcase
        if (req.cmd inside {CMD_SLT, CMD_SLTU, CMD_SEQ, CMD_SNE, CMD_SGE, CMD_SGEU}) begin
            rsp.res = `IALU_XLEN'(rsp.cmp);             // Zero-extended flag
        end
    end

endmodule

// ==== src/ialu_ctrl_pkg.sv ====
// ialu internal control types
// State encodings of both FSMs and the main adder flags

package ialu_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MUL_WAIT,    // Multiplier busy
        ST_DONE         // ack high, waiting for req to drop
    } ialu_state_e;

    typedef enum logic {
        MUL_IDLE,
        MUL_ITER
    } ialu_mul_state_e;

    typedef struct packed {
        logic zero;
        logic sign;
        logic ovf;
        logic carry;    // Borrow when subtracting
    } ialu_flags_s;

endpackage

// ==== src/ialu_op_pkg.sv ====
// ialu operation types
// Opcodes and the request/response words seen at the ALU boundary

`include "ialu_defs.svh"

package ialu_op_pkg;

    typedef enum logic [4:0] {
        CMD_NOP,
        CMD_AND,
        CMD_OR,
        CMD_XOR,
        CMD_ADD,
        CMD_SUB,
        CMD_SLT,        // Signed less than
        CMD_SLTU,       // Unsigned less than
        CMD_SEQ,
        CMD_SNE,
        CMD_SGE,
        CMD_SGEU,
        CMD_SLL,
        CMD_SRL,
        CMD_SRA,
        CMD_MUL,        // Low word
        CMD_MULH,       // High word, signed x signed
        CMD_MULHSU,     // High word, signed x unsigned
        CMD_MULHU       // High word, unsigned x unsigned
    } ialu_cmd_e;

    typedef struct packed {
        ialu_cmd_e              cmd;
        logic [`IALU_XLEN-1:0]  op1;
        logic [`IALU_XLEN-1:0]  op2;
    } ialu_req_s;

    typedef struct packed {
        logic [`IALU_XLEN-1:0]  res;
        logic                   cmp;    // Compare flag
    } ialu_rsp_s;

endpackage

// ==== include/ialu_defs.svh ====
// ialu shared sizes
// Data width, shift amount width and the iteration count of the multiplier

`ifndef IALU_DEFS_SVH
`define IALU_DEFS_SVH

//--------------------------------------------------
// Datapath
//--------------------------------------------------
`define IALU_XLEN       32  // Operand and result width
`define IALU_SHAMT_W    5   // Shift amount taken from op2

//--------------------------------------------------
// Sequential multiplier
//--------------------------------------------------
// One operand bit per cycle, so the count follows the data width
`define IALU_MUL_ITERS  32
`define IALU_CNT_W      5   // Counts IALU_MUL_ITERS-1 down to 0

`endif
